/* test/rtc_patterns.txt */
// One hex word per line: 0-5 chip preload sec..year, 6-11 write inputs sec..year,
// 12-13 expected timeOut/dateOut after first read sweep, 14-15 after the write sweep
// Chip registers 0x21 to 0x26
45
30
12
15
07
24
// secIn to yearIn during the write sweep
59
58
23
31
12
99
// Read sweep of the preloaded chip, {hour,min,sec} and {year,month,day}
123045
240715
// Read sweep after the write sweep
235859
991231

/* rtcCtrlTop.f */
+incdir+include
source/rtcBusPkg.sv
source/rtcTimePkg.sv
source/rtcModeFsm.sv
source/rtcFrameTimer.sv
source/rtcSequencer.sv
source/rtcBusPort.sv
source/rtcFieldBank.sv
source/rtcCtrlTop.sv
test/rtcCtrl_asserts.sv
test/rtcCtrlTb.sv

/* Makefile */
# Verilator build and run of the RTC controller testbench

VERILATOR ?= verilator
TOP       ?= rtcCtrlTb
FILELIST  ?= rtcCtrlTop.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/rtcCtrlTb.sv */
`timescale 1ns/10ps

`include "rtc_cfg.svh"

module rtcCtrlTb;

    localparam int frameLen = `RTC_FRAME_LEN;
    localparam int csLen    = `RTC_ADDR_CS_END - `RTC_ADDR_CS_START + 1;

    logic                   reloj;
    logic                   resetM;
    logic                   progTime;
    logic                   progDate;
    logic                   rtcInit;
    logic [`RTC_DATA_W-1:0] secIn;
    logic [`RTC_DATA_W-1:0] minIn;
    logic [`RTC_DATA_W-1:0] hourIn;
    logic [`RTC_DATA_W-1:0] dayIn;
    logic [`RTC_DATA_W-1:0] monthIn;
    logic [`RTC_DATA_W-1:0] yearIn;
    wire                    cs;
    wire                    rd;
    wire                    wr;
    wire                    addrData;
    wire  [`RTC_DATA_W-1:0] dirDato;
    rtcTimePkg::rtcTimeT    timeOut;
    rtcTimePkg::rtcDateT    dateOut;
    rtcBusPkg::rtcModeT     mode;

    logic [23:0]            patMem [0:15];
    logic [`RTC_DATA_W-1:0] chipRegs [0:255];
    logic [`RTC_DATA_W-1:0] chipAddr;
    logic [`RTC_DATA_W-1:0] logAddr [$];
    logic [`RTC_DATA_W-1:0] logData [$];
    integer                 seed;
    int                     mismatchCnt;
    int                     failCnt;

    // Bus monitor state
    logic                   prevCs;
    logic                   prevAd;
    rtcBusPkg::rtcModeT     prevMode;
    logic                   frameSeen;
    int                     csRun;
    int                     csWindows;
    int                     frameCycles;

    always #5 reloj = ~reloj;

    rtcCtrlTop dut_i (
        .reloj    (reloj),
        .resetM   (resetM),
        .progTime (progTime),
        .progDate (progDate),
        .rtcInit  (rtcInit),
        .secIn    (secIn),
        .minIn    (minIn),
        .hourIn   (hourIn),
        .dayIn    (dayIn),
        .monthIn  (monthIn),
        .yearIn   (yearIn),
        .cs       (cs),
        .rd       (rd),
        .wr       (wr),
        .addrData (addrData),
        .dirDato  (dirDato),
        .timeOut  (timeOut),
        .dateOut  (dateOut),
        .mode     (mode)
    );

    ////////////////////////////////////////////////////////////////////////////
    // RTC chip model

    assign dirDato = (!rd) ? chipRegs[chipAddr] : 'z;

    // Address while A/D is low, data otherwise
    always @(posedge wr)
    begin
        if (!resetM)
        begin
            if (!addrData)
                chipAddr = dirDato;
            else
            begin
                chipRegs[chipAddr] = dirDato;
                logAddr.push_back(chipAddr);
                logData.push_back(dirDato);
            end
        end
    end

    task automatic stepClk();
        @(posedge reloj);
        #1;
    endtask

    task automatic checkWord(input string name, input logic [23:0] got, input logic [23:0] exp);
        if (got !== exp)
        begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            mismatchCnt++;
        end
    endtask

    function automatic logic [7:0] itemAddr(input int idx);
        case (idx)
            0:       itemAddr = `RTC_ADDR_SEC;
            1:       itemAddr = `RTC_ADDR_MIN;
            2:       itemAddr = `RTC_ADDR_HOUR;
            3:       itemAddr = `RTC_ADDR_DAY;
            4:       itemAddr = `RTC_ADDR_MONTH;
            5:       itemAddr = `RTC_ADDR_YEAR;
            default: itemAddr = `RTC_ADDR_CMD;
        endcase
    endfunction

    function automatic bit logHas(input logic [7:0] addr, input logic [7:0] data);
        bit found;
        found = 1'b0;
        foreach (logAddr[k])
            if (logAddr[k] == addr && logData[k] == data)
                found = 1'b1;
        return found;
    endfunction

    task automatic waitWrite(input logic [7:0] addr, input logic [7:0] data, input int limit);
        int n;
        n = 0;
        while (!logHas(addr, data) && n < limit)
        begin
            stepClk();
            n++;
        end
        if (!logHas(addr, data))
        begin
            $display("Timeout: chip never saw 0x%h written to register 0x%h", data, addr);
            failCnt++;
        end
    endtask

    task automatic waitLogSize(input int size, input int limit);
        int n;
        n = 0;
        while (logAddr.size() < size && n < limit)
        begin
            stepClk();
            n++;
        end
        if (logAddr.size() < size)
        begin
            $display("Timeout: only %0d of %0d chip writes arrived", logAddr.size(), size);
            failCnt++;
        end
    endtask

    task automatic waitFields(input logic [23:0] expTime, input logic [23:0] expDate,
                              input int limit);
        int n;
        n = 0;
        while ((timeOut !== expTime || dateOut !== expDate) && n < limit)
        begin
            stepClk();
            n++;
        end
        if (timeOut !== expTime || dateOut !== expDate)
        begin
            $display("Timeout: read sweep did not deliver the expected fields");
            failCnt++;
        end
        checkWord("timeOut", timeOut, expTime);
        checkWord("dateOut", dateOut, expDate);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Frame monitor for cs windows and mode changes

    always @(negedge reloj)
    begin
        if (resetM)
        begin
            prevCs      = 1'b1;
            prevAd      = 1'b1;
            prevMode    = mode;
            frameSeen   = 1'b0;
            csRun       = 0;
            csWindows   = 0;
            frameCycles = 0;
        end
        else
        begin
            frameCycles++;
            if (!cs)
                csRun++;
            if (cs && !prevCs)
            begin
                checkWord("csLowCycles", csRun, csLen);
                csWindows++;
                csRun = 0;
            end
            if (mode !== prevMode && !(prevAd && !addrData))
            begin
                $display("Error: mode changed in the middle of a frame");
                failCnt++;
            end
            // A/D falls once per frame
            if (!addrData && prevAd)
            begin
                if (frameSeen)
                begin
                    checkWord("csWindowsPerFrame", csWindows, 2);
                    checkWord("frameCycles", frameCycles, frameLen);
                end
                frameSeen   = 1'b1;
                csWindows   = 0;
                frameCycles = 0;
            end
            prevCs   = cs;
            prevAd   = addrData;
            prevMode = mode;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial
    begin
        logic [31:0] rnd;
        int          gap;
        seed        = 32'h1ed2a232;
        mismatchCnt = 0;
        failCnt     = 0;
        reloj       = 1'b0;
        resetM      = 1'b1;
        progTime    = 1'b0;
        progDate    = 1'b0;
        rtcInit     = 1'b1;
        secIn       = '0;
        minIn       = '0;
        hourIn      = '0;
        dayIn       = '0;
        monthIn     = '0;
        yearIn      = '0;
        chipAddr    = '0;
        $readmemh("test/rtc_patterns.txt", patMem);
        for (int k = 0; k < 256; k++)
            chipRegs[k] = $random(seed);
        for (int k = 0; k < 6; k++)
            chipRegs[itemAddr(k)] = patMem[k][7:0];

        // Strobes idle and banks clear while reset is held
        repeat (8)
        begin
            stepClk();
            checkWord("cs", cs, 1'b1);
            checkWord("rd", rd, 1'b1);
            checkWord("wr", wr, 1'b1);
            checkWord("addrData", addrData, 1'b1);
            checkWord("timeOut", timeOut, 24'h0);
            checkWord("dateOut", dateOut, 24'h0);
            checkWord("mode", mode, rtcBusPkg::modeInit);
        end
        resetM = 1'b0;

        waitWrite(`RTC_ADDR_CTRL, `RTC_INIT_WORD, 2 * frameLen + 8);
        checkWord("mode", mode, rtcBusPkg::modeInit);

        rtcInit = 1'b0;
        waitFields(patMem[12], patMem[13], 8 * frameLen);
        checkWord("mode", mode, rtcBusPkg::modeRead);

        // Write sweep of six fields and then the transfer command
        secIn   = patMem[6][7:0];
        minIn   = patMem[7][7:0];
        hourIn  = patMem[8][7:0];
        dayIn   = patMem[9][7:0];
        monthIn = patMem[10][7:0];
        yearIn  = patMem[11][7:0];
        logAddr.delete();
        logData.delete();
        progTime = 1'b1;
        waitLogSize(7, 9 * frameLen);
        checkWord("mode", mode, rtcBusPkg::modeWrite);
        progTime = 1'b0;
        if (logAddr.size() >= 7)
        begin
            for (int k = 0; k < 7; k++)
            begin
                checkWord("writeAddr", logAddr[k], itemAddr(k));
                checkWord("writeData", logData[k],
                          (k < 6) ? patMem[6 + k] : 24'(`RTC_TRANSFER_CMD));
            end
        end

        waitFields(patMem[14], patMem[15], 9 * frameLen);
        checkWord("mode", mode, rtcBusPkg::modeRead);

        // Switches flip at arbitrary points inside frames
        repeat (12)
        begin
            rnd = $random(seed);
            gap = 5 + int'(rnd[10:5]);
            repeat (gap)
                stepClk();
            rtcInit  = rnd[0] & rnd[1];
            progTime = rnd[2];
            progDate = rnd[3];
        end
        rtcInit  = 1'b0;
        progTime = 1'b0;
        progDate = 1'b0;
        repeat (3 * frameLen)
            stepClk();
        checkWord("mode", mode, rtcBusPkg::modeRead);

        $display("Errors: %0d mismatches, %0d other failures", mismatchCnt, failCnt);
        if (mismatchCnt == 0 && failCnt == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* test/rtcCtrl_asserts.sv */
`timescale 1ns/10ps

`include "rtc_cfg.svh"

module rtcCtrlAsserts (
    input logic reloj,
    input logic resetM,
    input logic cs,
    input logic rd,
    input logic wr,
    input logic frameStart
);

    logic [5:0] sinceStart;
    logic       started;

    // Cycles since the last frame start
    always_ff @(posedge reloj)
    begin
        if (resetM)
        begin
            sinceStart <= 6'd0;
            started    <= 1'b0;
        end
        else if (frameStart)
        begin
            sinceStart <= 6'd1;
            started    <= 1'b1;
        end
        else
            sinceStart <= sinceStart + 6'd1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Strobe rules

    rdWrExclusive: assert property (@(posedge reloj) disable iff (resetM) (rd || wr))
        else $error("rd and wr are low together");

    rdInsideCs: assert property (@(posedge reloj) disable iff (resetM) (!rd |-> !cs))
        else $error("rd is low outside a cs window");

    // One frame start every frame length, no earlier and no later
    frameOnTime: assert property (@(posedge reloj) disable iff (resetM)
        (started && frameStart) |-> (sinceStart == 6'(`RTC_FRAME_LEN)))
        else $error("frameStart came early");

    frameNotLate: assert property (@(posedge reloj) disable iff (resetM)
        (started && !frameStart) |-> (sinceStart < 6'(`RTC_FRAME_LEN)))
        else $error("frameStart is overdue");

endmodule

bind rtcCtrlTop rtcCtrlAsserts asserts_i (
    .reloj      (reloj),
    .resetM     (resetM),
    .cs         (cs),
    .rd         (rd),
    .wr         (wr),
    .frameStart (frameStart)
);

/* source/rtcCtrlTop.sv */
`timescale 1ns/10ps

`include "rtc_cfg.svh"

module rtcCtrlTop (
    input  logic                   reloj,
    input  logic                   resetM,
    input  logic                   progTime,
    input  logic                   progDate,
    input  logic                   rtcInit,
    input  logic [`RTC_DATA_W-1:0] secIn,
    input  logic [`RTC_DATA_W-1:0] minIn,
    input  logic [`RTC_DATA_W-1:0] hourIn,
    input  logic [`RTC_DATA_W-1:0] dayIn,
    input  logic [`RTC_DATA_W-1:0] monthIn,
    input  logic [`RTC_DATA_W-1:0] yearIn,
    output logic                   cs,
    output logic                   rd,
    output logic                   wr,
    output logic                   addrData,
    inout  wire  [`RTC_DATA_W-1:0] dirDato,
    output rtcTimePkg::rtcTimeT    timeOut,
    output rtcTimePkg::rtcDateT    dateOut,
    output rtcBusPkg::rtcModeT     mode
);

    logic                   frameStart;
    logic [4:0]             frameCnt;
    logic [`RTC_DATA_W-1:0] busAddr;
    logic [`RTC_DATA_W-1:0] writeData;
    rtcBusPkg::rtcItemKindT itemKind;
    logic [1:0]             slot;
    logic [`RTC_DATA_W-1:0] readByte;
    logic                   captureStb;

    rtcModeFsm modeFsm_i (
        .reloj      (reloj),
        .resetM     (resetM),
        .progTime   (progTime),
        .progDate   (progDate),
        .rtcInit    (rtcInit),
        .frameStart (frameStart),
        .mode       (mode)
    );

    rtcFrameTimer frameTimer_i (
        .reloj      (reloj),
        .resetM     (resetM),
        .mode       (mode),
        .frameStart (frameStart),
        .frameCnt   (frameCnt),
        .cs         (cs),
        .rd         (rd),
        .wr         (wr),
        .addrData   (addrData)
    );

    rtcSequencer sequencer_i (
        .reloj      (reloj),
        .resetM     (resetM),
        .mode       (mode),
        .frameStart (frameStart),
        .secIn      (secIn),
        .minIn      (minIn),
        .hourIn     (hourIn),
        .dayIn      (dayIn),
        .monthIn    (monthIn),
        .yearIn     (yearIn),
        .busAddr    (busAddr),
        .writeData  (writeData),
        .itemKind   (itemKind),
        .slot       (slot)
    );

    rtcBusPort busPort_i (
        .reloj      (reloj),
        .resetM     (resetM),
        .mode       (mode),
        .frameCnt   (frameCnt),
        .busAddr    (busAddr),
        .writeData  (writeData),
        .dirDato    (dirDato),
        .readByte   (readByte),
        .captureStb (captureStb)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Payload banks that each pick their own item kind
    ////////////////////////////////////////////////////////////////////////////

    rtcFieldBank #(
        .fieldT   (rtcTimePkg::rtcTimeT),
        .bankKind (rtcBusPkg::itemTime)
    ) timeBank (
        .reloj      (reloj),
        .resetM     (resetM),
        .captureStb (captureStb),
        .itemKind   (itemKind),
        .slot       (slot),
        .readByte   (readByte),
        .fields     (timeOut)
    );

    rtcFieldBank #(
        .fieldT   (rtcTimePkg::rtcDateT),
        .bankKind (rtcBusPkg::itemDate)
    ) dateBank (
        .reloj      (reloj),
        .resetM     (resetM),
        .captureStb (captureStb),
        .itemKind   (itemKind),
        .slot       (slot),
        .readByte   (readByte),
        .fields     (dateOut)
    );

endmodule

/* source/rtcFieldBank.sv */
`timescale 1ns/10ps

`include "rtc_cfg.svh"

module rtcFieldBank #(
    parameter type                    fieldT   = logic [23:0],
    parameter rtcBusPkg::rtcItemKindT bankKind = rtcBusPkg::itemTime
) (
    input  logic                   reloj,
    input  logic                   resetM,
    input  logic                   captureStb,
    input  rtcBusPkg::rtcItemKindT itemKind,
    input  logic [1:0]             slot,
    input  logic [`RTC_DATA_W-1:0] readByte,
    output fieldT                  fields
);

    localparam int bankW   = $bits(fieldT);
    localparam int slotCnt = bankW / `RTC_DATA_W;

    logic [bankW-1:0] bankBits;
    logic             hit;

    // Only bytes meant for this payload, and only existing slots
    assign hit = captureStb && (itemKind == bankKind) && (slot < slotCnt);

    always_ff @(posedge reloj)
    begin
        if (resetM)
            bankBits <= '0;
        else if (hit)
            bankBits[slot * `RTC_DATA_W +: `RTC_DATA_W] <= readByte;
    end

    assign fields = fieldT'(bankBits);

endmodule

/* source/rtcBusPort.sv */
`timescale 1ns/10ps

`include "rtc_cfg.svh"

module rtcBusPort (
    input  logic                   reloj,
    input  logic                   resetM,
    input  rtcBusPkg::rtcModeT     mode,
    input  logic [4:0]             frameCnt,
    input  logic [`RTC_DATA_W-1:0] busAddr,
    input  logic [`RTC_DATA_W-1:0] writeData,
    inout  wire  [`RTC_DATA_W-1:0] dirDato,
    output logic [`RTC_DATA_W-1:0] readByte,
    output logic                   captureStb
);

    logic [4:0]             nextCnt;
    logic                   busOe;
    logic [`RTC_DATA_W-1:0] busOut;
    logic                   sampleNow;

    assign nextCnt = (frameCnt == 5'(`RTC_FRAME_LEN - 1)) ? 5'd0 : frameCnt + 5'd1;

    // Address first, then write data unless the chip is talking
    always_ff @(posedge reloj)
    begin
        if (resetM)
            busOe <= 1'b0;
        else
            busOe <= (nextCnt <= `RTC_ADDR_DRIVE_END) || (mode != rtcBusPkg::modeRead);
    end

    assign busOut  = (frameCnt <= `RTC_ADDR_DRIVE_END) ? busAddr : writeData;
    assign dirDato = busOe ? busOut : 'z;

    ////////////////////////////////////////////////////////////////////////////
    // Read capture
    ////////////////////////////////////////////////////////////////////////////

    assign sampleNow = (frameCnt == `RTC_SAMPLE_CYCLE) && (mode == rtcBusPkg::modeRead);

    always_ff @(posedge reloj)
    begin
        if (sampleNow)
            readByte <= dirDato;
    end

    always_ff @(posedge reloj)
    begin
        if (resetM)
            captureStb <= 1'b0;
        else
            captureStb <= sampleNow;
    end

endmodule

/* source/rtcSequencer.sv */
`timescale 1ns/10ps

`include "rtc_cfg.svh"

module rtcSequencer (
    input  logic                   reloj,
    input  logic                   resetM,
    input  rtcBusPkg::rtcModeT     mode,
    input  logic                   frameStart,
    input  logic [`RTC_DATA_W-1:0] secIn,
    input  logic [`RTC_DATA_W-1:0] minIn,
    input  logic [`RTC_DATA_W-1:0] hourIn,
    input  logic [`RTC_DATA_W-1:0] dayIn,
    input  logic [`RTC_DATA_W-1:0] monthIn,
    input  logic [`RTC_DATA_W-1:0] yearIn,
    output logic [`RTC_DATA_W-1:0] busAddr,
    output logic [`RTC_DATA_W-1:0] writeData,
    output rtcBusPkg::rtcItemKindT itemKind,
    output logic [1:0]             slot
);

    logic [2:0]             itemIdx;
    logic [2:0]             lastIdx;
    logic [2:0]             dateIdx;
    logic                   stepStb;
    rtcBusPkg::rtcModeT     prevMode;
    logic [`RTC_DATA_W-1:0] fieldAddr;
    logic [`RTC_DATA_W-1:0] fieldVal;

    // Last item index of each mode
    always_comb
    begin
        case (mode)
            rtcBusPkg::modeRead:  lastIdx = 3'd5;
            rtcBusPkg::modeWrite: lastIdx = 3'd6;
            default:              lastIdx = 3'd0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Item index
    ////////////////////////////////////////////////////////////////////////////

    // Steps one cycle after frameStart when the new mode is visible
    always_ff @(posedge reloj)
    begin
        if (resetM)
        begin
            stepStb  <= 1'b0;
            itemIdx  <= 3'd0;
            prevMode <= rtcBusPkg::modeInit;
        end
        else
        begin
            stepStb <= frameStart;
            if (stepStb)
            begin
                prevMode <= mode;
                if (mode != prevMode)
                    itemIdx <= 3'd0;
                else if (itemIdx >= lastIdx)
                    itemIdx <= 3'd0;
                else
                    itemIdx <= itemIdx + 3'd1;
            end
        end
    end

    // Time and date registers in sweep order with the transfer command last
    always_comb
    begin
        case (itemIdx)
            3'd0:
            begin
                fieldAddr = `RTC_ADDR_SEC;
                fieldVal  = secIn;
            end
            3'd1:
            begin
                fieldAddr = `RTC_ADDR_MIN;
                fieldVal  = minIn;
            end
            3'd2:
            begin
                fieldAddr = `RTC_ADDR_HOUR;
                fieldVal  = hourIn;
            end
            3'd3:
            begin
                fieldAddr = `RTC_ADDR_DAY;
                fieldVal  = dayIn;
            end
            3'd4:
            begin
                fieldAddr = `RTC_ADDR_MONTH;
                fieldVal  = monthIn;
            end
            3'd5:
            begin
                fieldAddr = `RTC_ADDR_YEAR;
                fieldVal  = yearIn;
            end
            default:
            begin
                fieldAddr = `RTC_ADDR_CMD;
                fieldVal  = `RTC_TRANSFER_CMD;
            end
        endcase
    end

    assign dateIdx = itemIdx - 3'd3;

    always_comb
    begin
        busAddr   = fieldAddr;
        writeData = fieldVal;
        itemKind  = rtcBusPkg::itemCtrl;
        slot      = 2'd0;
        case (mode)
            rtcBusPkg::modeInit:
            begin
                busAddr   = `RTC_ADDR_CTRL;
                writeData = `RTC_INIT_WORD;
            end
            rtcBusPkg::modeRead:
            begin
                writeData = '0;
                if (itemIdx < 3'd3)
                begin
                    itemKind = rtcBusPkg::itemTime;
                    slot     = itemIdx[1:0];
                end
                else
                begin
                    itemKind = rtcBusPkg::itemDate;
                    slot     = dateIdx[1:0];
                end
            end
            // Write keeps the field table as is
            default:
            begin
                itemKind = rtcBusPkg::itemCtrl;
            end
        endcase
    end

endmodule

/* source/rtcFrameTimer.sv */
`timescale 1ns/10ps

`include "rtc_cfg.svh"

module rtcFrameTimer (
    input  logic               reloj,
    input  logic               resetM,
    input  rtcBusPkg::rtcModeT mode,
    output logic               frameStart,
    output logic [4:0]         frameCnt,
    output logic               cs,
    output logic               rd,
    output logic               wr,
    output logic               addrData
);

    logic [4:0] nextCnt;
    logic       adWin;
    logic       addrWin;
    logic       dataWin;
    logic       isRead;

    // Free-running frame counter
    assign nextCnt = (frameCnt == 5'(`RTC_FRAME_LEN - 1)) ? 5'd0 : frameCnt + 5'd1;

    always_ff @(posedge reloj)
    begin
        if (resetM)
            frameCnt <= 5'd0;
        else
            frameCnt <= nextCnt;
    end

    assign frameStart = (frameCnt == 5'd0);

    ////////////////////////////////////////////////////////////////////////////
    // Strobe generation
    ////////////////////////////////////////////////////////////////////////////

    // Windows are decoded one cycle ahead so the registered strobes
    // line up with the frame count
    assign adWin   = (nextCnt >= `RTC_AD_LO_START) && (nextCnt <= `RTC_AD_LO_END);
    assign addrWin = (nextCnt >= `RTC_ADDR_CS_START) && (nextCnt <= `RTC_ADDR_CS_END);
    assign dataWin = (nextCnt >= `RTC_DATA_CS_START) && (nextCnt <= `RTC_DATA_CS_END);
    assign isRead  = (mode == rtcBusPkg::modeRead);

    always_ff @(posedge reloj)
    begin
        if (resetM)
        begin
            cs       <= 1'b1;
            rd       <= 1'b1;
            wr       <= 1'b1;
            addrData <= 1'b1;
        end
        else
        begin
            cs       <= !(addrWin || dataWin);
            rd       <= !(dataWin && isRead);
            // Address latch pulse, plus data pulse when writing
            wr       <= !(addrWin || (dataWin && !isRead));
            addrData <= !adWin;
        end
    end

endmodule

/* source/rtcModeFsm.sv */
`timescale 1ns/10ps

module rtcModeFsm (
    input  logic               reloj,
    input  logic               resetM,
    input  logic               progTime,
    input  logic               progDate,
    input  logic               rtcInit,
    input  logic               frameStart,
    output rtcBusPkg::rtcModeT mode
);

    logic progTimeReg;
    logic progDateReg;
    logic rtcInitReg;
    rtcBusPkg::rtcModeT nextMode;

    // Switch sampling
    always_ff @(posedge reloj)
    begin
        if (resetM)
        begin
            progTimeReg <= 1'b0;
            progDateReg <= 1'b0;
            rtcInitReg  <= 1'b0;
        end
        else
        begin
            progTimeReg <= progTime;
            progDateReg <= progDate;
            rtcInitReg  <= rtcInit;
        end
    end

    // Init wins, then any program switch, read otherwise
    always_comb
    begin
        if (rtcInitReg)
            nextMode = rtcBusPkg::modeInit;
        else if (progTimeReg || progDateReg)
            nextMode = rtcBusPkg::modeWrite;
        else
            nextMode = rtcBusPkg::modeRead;
    end

    // Mode only moves on a frame boundary so no transaction is cut short
    always_ff @(posedge reloj)
    begin
        if (resetM)
            mode <= rtcBusPkg::modeInit;
        else if (frameStart)
            mode <= nextMode;
    end

endmodule

/* source/rtcTimePkg.sv */
`include "rtc_cfg.svh"

package rtcTimePkg;

    // Time of day with slot 0 as the lowest byte
    typedef struct packed
    {
        logic [`RTC_DATA_W-1:0] hour;
        logic [`RTC_DATA_W-1:0] min;
        logic [`RTC_DATA_W-1:0] sec;
    } rtcTimeT;

    // Calendar date in the same slot order
    typedef struct packed
    {
        logic [`RTC_DATA_W-1:0] year;
        logic [`RTC_DATA_W-1:0] month;
        logic [`RTC_DATA_W-1:0] day;
    } rtcDateT;

endpackage

/* source/rtcBusPkg.sv */
package rtcBusPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Controller mode
    ////////////////////////////////////////////////////////////////////////////

    // Init writes the control word, read sweeps the clock registers,
    // write loads the six fields and then issues the transfer command
    typedef enum logic [1:0]
    {
        modeInit  = 2'd0,
        modeRead  = 2'd1,
        modeWrite = 2'd2
    } rtcModeT;

    ////////////////////////////////////////////////////////////////////////////
    // Bus item kind
    ////////////////////////////////////////////////////////////////////////////

    // Tells which payload a read byte lands in
    typedef enum logic [1:0]
    {
        itemTime = 2'd0,
        itemDate = 2'd1,
        itemCtrl = 2'd2
    } rtcItemKindT;

endpackage

/* include/rtc_cfg.svh */
`ifndef RTC_CFG_SVH
`define RTC_CFG_SVH

// Bus and frame geometry
`define RTC_DATA_W          8
`define RTC_FRAME_LEN       32

// Strobe windows in frame cycles (inclusive)
`define RTC_AD_LO_START     1
`define RTC_AD_LO_END       10
`define RTC_ADDR_CS_START   2
`define RTC_ADDR_CS_END     8
`define RTC_DATA_CS_START   20
`define RTC_DATA_CS_END     26
`define RTC_ADDR_DRIVE_END  10
`define RTC_SAMPLE_CYCLE    26

// RTC register map
`define RTC_ADDR_SEC        8'h21
`define RTC_ADDR_MIN        8'h22
`define RTC_ADDR_HOUR       8'h23
`define RTC_ADDR_DAY        8'h24
`define RTC_ADDR_MONTH      8'h25
`define RTC_ADDR_YEAR       8'h26
`define RTC_ADDR_CTRL       8'h02
`define RTC_ADDR_CMD        8'hF1

// Command words
`define RTC_INIT_WORD       8'h10
`define RTC_TRANSFER_CMD    8'hF0

`endif
